// ==== dv/fu_tb.sv ====
/*
 * Integer execution stage testbench
 */
`default_nettype none

module fu_tb import fu_pkg::*; ();

    localparam logic [31:0] SEED        = 32'ha34;
    localparam int          NUM_OPS     = 300;           // Accepted ops per unit
    localparam int          CYCLE_LIMIT = NUM_OPS * 6 + 100;

    logic           clk;
    logic           alu_reset;
    logic           start_drv [3];      // 0 ALU, 1 multiply, 2 branch
    fu_packet_t     pkt_drv [3];
    logic           alu_ready, alu_valid, mult_ready, mult_valid;
    logic           branch_ready, branch_valid;
    xlen_t          alu_result, mult_result;
    branch_result_t branch_result;

    logic [31:0]    rng_state;
    logic           m_busy [3];
    logic           pend_accept [3];
    int             m_cnt [3];
    int             issued [3];
    logic [32:0]    alu_q [$];
    logic [32:0]    mult_q [$];
    logic [32:0]    branch_q [$];
    int             value_errors, protocol_errors, ignored, cycles;

    tb_clock clock_gen (.clk_o(clk), .alu_reset_o(alu_reset));

    fu_top uut (
        .clk_i           (clk),
        .alu_reset_i     (alu_reset),
        .alu_start_i     (start_drv[0]),
        .alu_packet_i    (pkt_drv[0]),
        .mult_start_i    (start_drv[1]),
        .mult_packet_i   (pkt_drv[1]),
        .branch_start_i  (start_drv[2]),
        .branch_packet_i (pkt_drv[2]),
        .alu_ready_o     (alu_ready),
        .alu_valid_o     (alu_valid),
        .alu_result_o    (alu_result),
        .mult_ready_o    (mult_ready),
        .mult_valid_o    (mult_valid),
        .mult_result_o   (mult_result),
        .branch_ready_o  (branch_ready),
        .branch_valid_o  (branch_valid),
        .branch_result_o (branch_result)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic string unit_name(input int u);
        if (u == 0) return "ALU";
        else if (u == 1) return "MULT";
        return "BRANCH";
    endfunction

    function automatic int unit_latency(input int u);
        if (u == 0) return ALU_LATENCY;
        else if (u == 1) return MULT_LATENCY;
        return BRANCH_LATENCY;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic xlen_t ref_opa(input fu_packet_t p);
        if (p.opa_sel == OPA_IS_RS1) return p.rs1_value;
        else if (p.opa_sel == OPA_IS_NPC) return p.npc;
        else if (p.opa_sel == OPA_IS_PC) return p.pc;
        return '0;
    endfunction

    function automatic xlen_t ref_opb(input fu_packet_t p);
        xlen_t ins;
        xlen_t imm;
        ins = p.inst;
        imm = '0;
        case (p.opb_sel)
            OPB_IS_RS2:   imm = p.rs2_value;
            OPB_IS_I_IMM: imm = xlen_t'($signed(ins) >>> 20);
            OPB_IS_S_IMM: imm = (xlen_t'($signed(ins) >>> 20) & 32'hffff_ffe0) | {27'd0, ins[11:7]};
            OPB_IS_U_IMM: imm = ins & 32'hffff_f000;
            OPB_IS_B_IMM: begin
                imm[12]   = ins[31];
                imm[11]   = ins[7];
                imm[10:5] = ins[30:25];
                imm[4:1]  = ins[11:8];
                if (ins[31]) imm = imm | 32'hffff_e000;     // Sign above bit 12
            end
            OPB_IS_J_IMM: begin
                imm[20]    = ins[31];
                imm[19:12] = ins[19:12];
                imm[11]    = ins[20];
                imm[10:1]  = ins[30:21];
                if (ins[31]) imm = imm | 32'hfff0_0000;     // Sign above bit 20
            end
            default: imm = '0;
        endcase
        return imm;
    endfunction

    function automatic xlen_t ref_alu(input xlen_t a, input xlen_t b, input alu_func_e f);
        logic [63:0] wide;
        wide = {{32{a[31]}}, a} >> b[4:0];      // Arithmetic shift via a wide word
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SRL:  return a >> b[4:0];
            ALU_SLL:  return a << b[4:0];
            ALU_SRA:  return wide[31:0];
            default:  return '0;
        endcase
    endfunction

    function automatic xlen_t ref_mult(input xlen_t a, input xlen_t b, input alu_func_e f);
        longint      sa, sb, ub, prod_ss, prod_su;
        logic [63:0] prod_uu;
        sa      = longint'($signed(a));
        sb      = longint'($signed(b));
        ub      = {32'd0, b};
        prod_ss = sa * sb;
        prod_su = sa * ub;      // Magnitude stays below 2**63
        prod_uu = {32'd0, a} * {32'd0, b};
        case (f)
            ALU_MUL:    return prod_ss[31:0];
            ALU_MULH:   return prod_ss[63:32];
            ALU_MULHSU: return prod_su[63:32];
            ALU_MULHU:  return prod_uu[63:32];
            default:    return '0;
        endcase
    endfunction

    function automatic branch_result_t ref_branch(input fu_packet_t p);
        branch_result_t e;
        logic [2:0]     f3;
        logic [32:0]    diff;
        logic           eq, ltu, lt, cond;
        f3   = p.inst[14:12];
        diff = {1'b0, p.rs1_value} - {1'b0, p.rs2_value};
        eq   = diff[31:0] == 32'd0;
        ltu  = diff[32];                        // Borrow out
        lt   = (p.rs1_value[31] != p.rs2_value[31]) ? p.rs1_value[31] : ltu;
        // Upper funct3 bits pick the compare and bit 0 inverts it
        case (f3[2:1])
            2'b00:   cond = eq ^ f3[0];
            2'b10:   cond = lt ^ f3[0];
            2'b11:   cond = ltu ^ f3[0];
            default: cond = 1'b0;               // 010 and 011 are not branches
        endcase
        e.target = ref_alu(ref_opa(p), ref_opb(p), p.func);
        e.take   = p.uncond_branch | (p.cond_branch & cond);
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and tracking
    ////////////////////////////////////////////////////////////////////////////

    function automatic fu_packet_t random_packet(input int u);
        fu_packet_t  p;
        logic [31:0] r;
        logic [31:0] f;
        p.pc        = lcg_next() & ~32'h3;
        p.npc       = p.pc + 32'd4;
        p.inst      = lcg_next();
        p.rs1_value = lcg_next();
        r           = lcg_next();
        f           = lcg_next();
        p.rs2_value = (r[31:30] == 2'd0) ? p.rs1_value : lcg_next();   // Equal operands often
        p.opa_sel   = opa_sel_e'(r[19:18]);
        p.opb_sel   = opb_sel_e'(r[22:20]);      // Includes the unused codes
        if (u == 1) p.func = alu_func_e'(4'ha + {2'b00, r[17:16]});
        else p.func = alu_func_e'(4'(r[29:23] % 7'd10));
        p.cond_branch   = f[31];
        p.uncond_branch = f[30] & f[29];
        return p;
    endfunction

    task automatic drive_unit(input int u);
        logic [31:0] r;
        r = lcg_next();
        start_drv[u] = 1'b0;
        if (!m_busy[u] && issued[u] < NUM_OPS && r[31:29] != 3'd0) begin
            start_drv[u]   = 1'b1;
            pend_accept[u] = 1'b1;
            pkt_drv[u]     = random_packet(u);
        end else if (m_busy[u] && r[31:30] == 2'd0) begin
            start_drv[u] = 1'b1;        // Dropped by the busy unit
            pkt_drv[u]   = random_packet(u);
            ignored++;
        end
    endtask

    task automatic track_unit(input int u);
        logic        rdy, vld, exp_valid;
        logic [32:0] got, want;
        rdy = (u == 0) ? alu_ready : (u == 1) ? mult_ready : branch_ready;
        vld = (u == 0) ? alu_valid : (u == 1) ? mult_valid : branch_valid;
        got = (u == 0) ? {1'b0, alu_result} : (u == 1) ? {1'b0, mult_result} : branch_result;
        exp_valid = 1'b0;
        if (pend_accept[u]) begin
            m_busy[u] = 1'b1;
            m_cnt[u]  = 0;
            issued[u]++;
            if (u == 0) alu_q.push_back({1'b0, ref_alu(ref_opa(pkt_drv[u]),
                                                ref_opb(pkt_drv[u]), pkt_drv[u].func)});
            else if (u == 1) mult_q.push_back({1'b0, ref_mult(ref_opa(pkt_drv[u]),
                                                ref_opb(pkt_drv[u]), pkt_drv[u].func)});
            else branch_q.push_back(ref_branch(pkt_drv[u]));
        end else if (m_busy[u]) begin
            m_cnt[u]++;
            if (m_cnt[u] == unit_latency(u)) begin
                exp_valid = 1'b1;
                m_busy[u] = 1'b0;
            end
        end
        pend_accept[u] = 1'b0;
        if (vld !== exp_valid || rdy !== !m_busy[u]) begin
            $display("FAIL %0t: %s valid %b ready %b, expected valid %b ready %b",
                     $time, unit_name(u), vld, rdy, exp_valid, !m_busy[u]);
            protocol_errors++;
        end
        if (exp_valid) begin
            want = (u == 0) ? alu_q.pop_front() : (u == 1) ? mult_q.pop_front()
                                                           : branch_q.pop_front();
            if (got !== want) begin
                $display("FAIL %0t: %s result %h, expected %h", $time, unit_name(u), got, want);
                value_errors++;
            end
        end
    endtask

    function automatic logic all_done();
        for (int u = 0; u < 3; u++) begin
            if (issued[u] < NUM_OPS || m_busy[u] || pend_accept[u]) return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        rng_state       = SEED;
        value_errors    = 0;
        protocol_errors = 0;
        ignored         = 0;
        cycles          = 0;
        for (int u = 0; u < 3; u++) begin
            start_drv[u]   = 1'b0;
            pkt_drv[u]     = '0;
            m_busy[u]      = 1'b0;
            pend_accept[u] = 1'b0;
            m_cnt[u]       = 0;
            issued[u]      = 0;
        end

        @(negedge alu_reset);
        if (!alu_ready || !mult_ready || !branch_ready || alu_valid || mult_valid
                || branch_valid || alu_result !== '0 || mult_result !== '0
                || branch_result !== '0) begin
            $display("FAIL %0t: units not idle with zero results after reset", $time);
            protocol_errors++;
        end

        while (!all_done() && cycles < CYCLE_LIMIT) begin
            for (int u = 0; u < 3; u++) begin
                drive_unit(u);
            end
            @(negedge clk);
            cycles++;
            for (int u = 0; u < 3; u++) begin
                track_unit(u);
            end
        end

        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d with operations still open", cycles);
        end
        $display("Done after %0d cycles: %0d value errors, %0d protocol errors, %0d dropped starts",
                 cycles, value_errors, protocol_errors, ignored);
        if (value_errors == 0 && protocol_errors == 0 && cycles < CYCLE_LIMIT) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
/*
 * Testbench clock and reset
 */
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic alu_reset_o
);

    localparam int HALF_PERIOD  = 2;    // Period of 4
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset spans three rising edges, released on a falling edge
    initial begin
        alu_reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        alu_reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== fu_top.f ====
verilog/fu_pkg.sv
verilog/operand_select.sv
verilog/int_alu.sv
verilog/int_mult.sv
verilog/branch_resolve.sv
verilog/fu_slot.sv
verilog/fu_top.sv
dv/tb_clock.sv
dv/fu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the execution stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module fu_tb -f fu_top.f -o fu_tb_sim \
    && ./obj_dir/fu_tb_sim | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }

// ==== verilog/branch_resolve.sv ====
/*
 * Branch condition and target
 */
`default_nettype none

module branch_resolve import fu_pkg::*; (
    input  fu_packet_t     packet_i,
    input  xlen_t          opa_i,
    input  xlen_t          opb_i,
    output branch_result_t result_o
);

    logic [2:0] funct3;
    logic       cond;
    xlen_t      target;

    assign funct3 = packet_i.inst[14:12];

    // Target address through the same ALU as the integer unit
    int_alu target_alu (
        .opa_i    (opa_i),
        .opb_i    (opb_i),
        .func_i   (packet_i.func),
        .result_o (target)
    );

    // Condition always compares the register values
    always_comb begin
        case (funct3)
            3'b000:  cond = packet_i.rs1_value == packet_i.rs2_value;            // BEQ
            3'b001:  cond = packet_i.rs1_value != packet_i.rs2_value;            // BNE
            3'b100:  cond = $signed(packet_i.rs1_value) < $signed(packet_i.rs2_value);
            3'b101:  cond = $signed(packet_i.rs1_value) >= $signed(packet_i.rs2_value);
            3'b110:  cond = packet_i.rs1_value < packet_i.rs2_value;             // BLTU
            3'b111:  cond = packet_i.rs1_value >= packet_i.rs2_value;            // BGEU
            default: cond = 1'b0;
        endcase
    end

    assign result_o.target = target;

    // Jumps always go, branches only on a true condition
    assign result_o.take = packet_i.uncond_branch | (packet_i.cond_branch & cond);

endmodule

`default_nettype wire

// ==== verilog/fu_pkg.sv ====
/*
 * Integer execution stage definitions
 */
`default_nettype none

package fu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and latencies
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int SHAMT_W = $clog2(XLEN);      // Shift amount bits

    typedef logic [XLEN-1:0] xlen_t;

    // Cycles from an accepted start to the valid cycle
    localparam int ALU_LATENCY    = 1;
    localparam int MULT_LATENCY   = 4;
    localparam int BRANCH_LATENCY = 1;

    // Wide enough for the longest latency
    localparam int CNT_W = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Operand selects
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_sel_e;

    // Codes 6 and 7 are unused
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // Function codes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_AND    = 4'h2,
        ALU_SLT    = 4'h3,
        ALU_SLTU   = 4'h4,
        ALU_OR     = 4'h5,
        ALU_XOR    = 4'h6,
        ALU_SRL    = 4'h7,
        ALU_SLL    = 4'h8,
        ALU_SRA    = 4'h9,
        ALU_MUL    = 4'ha,       // Multiply unit only
        ALU_MULH   = 4'hb,
        ALU_MULHSU = 4'hc,
        ALU_MULHU  = 4'hd
    } alu_func_e;

    ////////////////////////////////////////////////////////////////////////////
    // Issue packet and results
    ////////////////////////////////////////////////////////////////////////////

    // Decoded instruction as handed to a unit on start
    typedef struct packed {
        xlen_t     pc;
        xlen_t     npc;
        xlen_t     inst;            // Raw instruction word
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        alu_func_e func;
        logic      cond_branch;
        logic      uncond_branch;
    } fu_packet_t;

    typedef struct packed {
        xlen_t target;
        logic  take;
    } branch_result_t;

endpackage

`default_nettype wire

// ==== verilog/fu_slot.sv ====
/*
 * Functional unit issue slot
 */
`default_nettype none

module fu_slot import fu_pkg::*; #(
    parameter type result_t = xlen_t,
    parameter int  LATENCY  = 1
) (
    input  logic       clk_i,
    input  logic       alu_reset_i,
    input  logic       start_i,
    input  fu_packet_t packet_i,
    input  result_t    result_i,
    output fu_packet_t held_o,
    output logic       ready_o,
    output logic       valid_o,
    output result_t    result_o
);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;        // Cycles left before completion
    logic             take_start;

    // Start counts only while idle
    assign take_start = start_i & ~busy_q;
    assign ready_o    = ~busy_q;

    ////////////////////////////////////////////////////////////////////////////
    // Control and result register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (alu_reset_i) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= 1'b0;                            // One-cycle pulse
            if (take_start) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(LATENCY - 1);
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q   <= 1'b0;                   // Ready with the valid edge
                    valid_o  <= 1'b1;
                    result_o <= result_i;
                end else begin
                    cnt_q <= cnt_q - CNT_W'(1);
                end
            end
        end
    end

    // Packet held for the combinational datapath
    always_ff @(posedge clk_i) begin
        if (take_start) begin
            held_o <= packet_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fu_top.sv ====
/*
 * Integer execution stage top
 */
`default_nettype none

module fu_top import fu_pkg::*; (
    input  logic           clk_i,
    input  logic           alu_reset_i,

    input  logic           alu_start_i,
    input  fu_packet_t     alu_packet_i,
    input  logic           mult_start_i,
    input  fu_packet_t     mult_packet_i,
    input  logic           branch_start_i,
    input  fu_packet_t     branch_packet_i,

    output logic           alu_ready_o,
    output logic           alu_valid_o,
    output xlen_t          alu_result_o,
    output logic           mult_ready_o,
    output logic           mult_valid_o,
    output xlen_t          mult_result_o,
    output logic           branch_ready_o,
    output logic           branch_valid_o,
    output branch_result_t branch_result_o
);

    fu_packet_t     alu_held, mult_held, branch_held;
    xlen_t          alu_opa, alu_opb, alu_calc;
    xlen_t          mult_opa, mult_opb, mult_calc;
    xlen_t          branch_opa, branch_opb;
    branch_result_t branch_calc;

    ////////////////////////////////////////////////////////////////////////////
    // ALU unit
    ////////////////////////////////////////////////////////////////////////////

    fu_slot #(.result_t(xlen_t), .LATENCY(ALU_LATENCY)) alu_slot (
        .clk_i       (clk_i),
        .alu_reset_i (alu_reset_i),
        .start_i     (alu_start_i),
        .packet_i    (alu_packet_i),
        .result_i    (alu_calc),
        .held_o      (alu_held),
        .ready_o     (alu_ready_o),
        .valid_o     (alu_valid_o),
        .result_o    (alu_result_o)
    );

    operand_select alu_ops (.packet_i(alu_held), .opa_o(alu_opa), .opb_o(alu_opb));

    int_alu alu_dp (.opa_i(alu_opa), .opb_i(alu_opb), .func_i(alu_held.func), .result_o(alu_calc));

    ////////////////////////////////////////////////////////////////////////////
    // Multiply unit
    ////////////////////////////////////////////////////////////////////////////

    fu_slot #(.result_t(xlen_t), .LATENCY(MULT_LATENCY)) mult_slot (
        .clk_i       (clk_i),
        .alu_reset_i (alu_reset_i),
        .start_i     (mult_start_i),
        .packet_i    (mult_packet_i),
        .result_i    (mult_calc),
        .held_o      (mult_held),
        .ready_o     (mult_ready_o),
        .valid_o     (mult_valid_o),
        .result_o    (mult_result_o)
    );

    operand_select mult_ops (.packet_i(mult_held), .opa_o(mult_opa), .opb_o(mult_opb));

    int_mult mult_dp (
        .opa_i    (mult_opa),
        .opb_i    (mult_opb),
        .func_i   (mult_held.func),
        .result_o (mult_calc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Branch unit
    ////////////////////////////////////////////////////////////////////////////

    fu_slot #(.result_t(branch_result_t), .LATENCY(BRANCH_LATENCY)) branch_slot (
        .clk_i       (clk_i),
        .alu_reset_i (alu_reset_i),
        .start_i     (branch_start_i),
        .packet_i    (branch_packet_i),
        .result_i    (branch_calc),
        .held_o      (branch_held),
        .ready_o     (branch_ready_o),
        .valid_o     (branch_valid_o),
        .result_o    (branch_result_o)
    );

    operand_select branch_ops (.packet_i(branch_held), .opa_o(branch_opa), .opb_o(branch_opb));

    branch_resolve branch_dp (
        .packet_i (branch_held),
        .opa_i    (branch_opa),
        .opb_i    (branch_opb),
        .result_o (branch_calc)     // Target and take decision
    );

endmodule

`default_nettype wire

// ==== verilog/int_alu.sv ====
/*
 * Combinational integer ALU
 */
`default_nettype none

module int_alu import fu_pkg::*; (
    input  xlen_t     opa_i,
    input  xlen_t     opb_i,
    input  alu_func_e func_i,
    output xlen_t     result_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // Only the low bits of B count for shifts
    assign shamt = opb_i[SHAMT_W-1:0];

    assign lt_signed   = $signed(opa_i) < $signed(opb_i);
    assign lt_unsigned = opa_i < opb_i;

    always_comb begin
        case (func_i)
            ALU_ADD:  result_o = opa_i + opb_i;
            ALU_SUB:  result_o = opa_i - opb_i;
            ALU_AND:  result_o = opa_i & opb_i;
            ALU_OR:   result_o = opa_i | opb_i;
            ALU_XOR:  result_o = opa_i ^ opb_i;

            // Compares give 0 or 1
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};

            ALU_SRL:  result_o = opa_i >> shamt;
            ALU_SLL:  result_o = opa_i << shamt;
            ALU_SRA:  result_o = xlen_t'($signed(opa_i) >>> shamt);   // Sign fill

            default:  result_o = '0;     // Multiply codes belong to int_mult
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/int_mult.sv ====
/*
 * Combinational integer multiplier
 */
`default_nettype none

module int_mult import fu_pkg::*; (
    input  xlen_t     opa_i,
    input  xlen_t     opb_i,
    input  alu_func_e func_i,
    output xlen_t     result_o
);

    logic [2*XLEN-1:0] opa_sx, opa_zx;
    logic [2*XLEN-1:0] opb_sx, opb_zx;
    logic [2*XLEN-1:0] prod_ss, prod_su, prod_uu;

    // Operands widened to 64 bits
    assign opa_sx = {{XLEN{opa_i[XLEN-1]}}, opa_i};
    assign opb_sx = {{XLEN{opb_i[XLEN-1]}}, opb_i};
    assign opa_zx = {{XLEN{1'b0}}, opa_i};
    assign opb_zx = {{XLEN{1'b0}}, opb_i};

    // Low 64 bits of each product are exact for the extended operands
    assign prod_ss = opa_sx * opb_sx;
    assign prod_su = opa_sx * opb_zx;   // Signed A by unsigned B
    assign prod_uu = opa_zx * opb_zx;

    always_comb begin
        case (func_i)
            ALU_MUL:    result_o = prod_ss[XLEN-1:0];
            ALU_MULH:   result_o = prod_ss[2*XLEN-1:XLEN];
            ALU_MULHSU: result_o = prod_su[2*XLEN-1:XLEN];
            ALU_MULHU:  result_o = prod_uu[2*XLEN-1:XLEN];
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/operand_select.sv ====
/*
 * Operand A and B selection
 */
`default_nettype none

module operand_select import fu_pkg::*; (
    input  fu_packet_t packet_i,
    output xlen_t      opa_o,
    output xlen_t      opb_o
);

    xlen_t inst;
    xlen_t i_imm, s_imm, b_imm, u_imm, j_imm;

    assign inst = packet_i.inst;

    // RV32 immediates, all sign extended from bit 31
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'h000};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Operand A
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (packet_i.opa_sel)
            OPA_IS_RS1:  opa_o = packet_i.rs1_value;
            OPA_IS_NPC:  opa_o = packet_i.npc;
            OPA_IS_PC:   opa_o = packet_i.pc;
            default:     opa_o = '0;             // OPA_IS_ZERO
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand B
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (packet_i.opb_sel)
            OPB_IS_RS2:   opb_o = packet_i.rs2_value;
            OPB_IS_I_IMM: opb_o = i_imm;
            OPB_IS_S_IMM: opb_o = s_imm;
            OPB_IS_B_IMM: opb_o = b_imm;
            OPB_IS_U_IMM: opb_o = u_imm;
            OPB_IS_J_IMM: opb_o = j_imm;
            default:      opb_o = '0;            // Unused select codes
        endcase
    end

endmodule

`default_nettype wire
